// ==== Makefile ====
# Verilator build and run for the read-side traffic controller testbench

TOP             ?= tb_vertex_cache_reuse_control
SIM_DIR         ?= obj_dir
FILE_LIST       ?= sources.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT       ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILE_LIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@output="$$(./$(SIM_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(SIM_DIR)

// ==== hw/graph_array_pkg.sv ====
// Graph array kinds, edge element layout and lane encodings shared by RTL and testbench
package graph_array_pkg;

	// Kind of graph array a read targets
	typedef enum logic [1:0] {
		array_job       = 2'd0,
		array_edge_data = 2'd1,
		array_vertex    = 2'd2,
		array_property  = 2'd3
	} array_kind_t;

	typedef logic [31:0] edge_element_t;
	typedef logic [2:0]  element_index_t;

	// Edge elements packed in one 256-bit line
	localparam int ELEMENTS_PER_LINE = 8;

	// Command lanes, also the arbiter's last grant
	typedef enum logic {
		lane_job  = 1'b0,
		lane_edge = 1'b1
	} lane_t;

	// Tag field is the 8-bit read bus tag
	typedef struct packed {
		logic          valid;
		edge_element_t element;
		logic [7:0]    tag;
	} edge_data_t;

endpackage

// ==== hw/read_bus_pkg.sv ====
// Memory read bus formats for commands, returning lines and responses, used by RTL and testbench
package read_bus_pkg;

	typedef logic [31:0]  address_t;
	typedef logic [255:0] cacheline_t;
	typedef logic [7:0]   read_tag_t;

	// Read command toward the memory read port
	typedef struct packed {
		logic                            valid;
		address_t                        address;
		graph_array_pkg::array_kind_t    kind;
		graph_array_pkg::element_index_t element;
		read_tag_t                       tag;
	} read_command_t;

	// Returning line with the command fields it answers
	typedef struct packed {
		logic                            valid;
		graph_array_pkg::array_kind_t    kind;
		graph_array_pkg::element_index_t element;
		read_tag_t                       tag;
		cacheline_t                      line;
	} read_data_t;

	typedef struct packed {
		logic       valid;
		read_tag_t  tag;
		logic [1:0] status;
	} read_response_t;

endpackage

// ==== hw/read_command_arbiter.sv ====
// Round-robin arbiter moving lane queue heads onto the memory read command port
`timescale 1ns/1ps

module read_command_arbiter (
	input  logic                        clock,
	input  logic                        rstn_internal,
	input  logic                        enabled,
	input  logic                        read_buffer_alfull,
	input  read_bus_pkg::read_command_t job_head,
	input  read_bus_pkg::read_command_t edge_head,
	input  logic                        job_empty,
	input  logic                        edge_empty,
	output logic                        job_pop,
	output logic                        edge_pop,
	output read_bus_pkg::read_command_t read_command_out
);

	logic                        alfull_q;
	graph_array_pkg::lane_t      last_grant;
	logic                        job_ready;
	logic                        edge_ready;
	logic                        grant_valid;
	graph_array_pkg::lane_t      grant_lane;
	logic                        out_valid;
	read_bus_pkg::read_command_t out_payload;

	////////////////////
	// Grant selection
	////////////////////

	always_comb begin
		job_ready   = enabled && !alfull_q && !job_empty;
		edge_ready  = enabled && !alfull_q && !edge_empty;
		grant_valid = job_ready || edge_ready;
		if (job_ready && edge_ready) begin
			// Both waiting, so the lane not served last wins
			if (last_grant == graph_array_pkg::lane_job) begin
				grant_lane = graph_array_pkg::lane_edge;
			end else begin
				grant_lane = graph_array_pkg::lane_job;
			end
		end else if (edge_ready) begin
			grant_lane = graph_array_pkg::lane_edge;
		end else begin
			grant_lane = graph_array_pkg::lane_job;
		end
	end

	assign job_pop  = grant_valid && (grant_lane == graph_array_pkg::lane_job);
	assign edge_pop = grant_valid && (grant_lane == graph_array_pkg::lane_edge);

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			alfull_q   <= 1'b0;
			last_grant <= graph_array_pkg::lane_edge;
			out_valid  <= 1'b0;
		end else begin
			alfull_q  <= read_buffer_alfull;
			out_valid <= grant_valid;
			if (grant_valid) begin
				last_grant <= grant_lane;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (grant_lane == graph_array_pkg::lane_edge) begin
			out_payload <= edge_head;
		end else begin
			out_payload <= job_head;
		end
	end

	always_comb begin
		read_command_out       = out_payload;
		read_command_out.valid = out_valid;
	end

	assert property (@(posedge clock) disable iff (!rstn_internal) !(job_pop && edge_pop));

endmodule

// ==== hw/read_command_classifier.sv ====
// Decode stage that registers incoming read commands and steers job and edge-data ones to a lane
`timescale 1ns/1ps

module read_command_classifier (
	input  logic                        clock,
	input  logic                        rstn_internal,
	input  logic                        enabled,
	input  read_bus_pkg::read_command_t command_in,
	output read_bus_pkg::read_command_t lane_command,
	output graph_array_pkg::lane_t      lane_select
);

	logic                        command_valid;
	read_bus_pkg::read_command_t command_payload;
	logic                        kind_accepted;
	graph_array_pkg::lane_t      decoded_lane;

	// Only job and edge-data kinds own a lane
	always_comb begin
		kind_accepted = 1'b1;
		decoded_lane  = graph_array_pkg::lane_job;
		case (command_in.kind)
			graph_array_pkg::array_job:       decoded_lane = graph_array_pkg::lane_job;
			graph_array_pkg::array_edge_data: decoded_lane = graph_array_pkg::lane_edge;
			default:                          kind_accepted = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			command_valid <= 1'b0;
		end else begin
			command_valid <= enabled && command_in.valid && kind_accepted;
		end
	end

	always_ff @(posedge clock) begin
		command_payload <= command_in;
		lane_select     <= decoded_lane;
	end

	always_comb begin
		lane_command       = command_payload;
		lane_command.valid = command_valid;
	end

	// Steered command and lane agree on the array kind
	assert property (@(posedge clock) disable iff (!rstn_internal)
		lane_command.valid |->
			(lane_command.kind == graph_array_pkg::array_job &&
				lane_select == graph_array_pkg::lane_job) ||
			(lane_command.kind == graph_array_pkg::array_edge_data &&
				lane_select == graph_array_pkg::lane_edge));

endmodule

// ==== hw/read_command_queue.sv ====
// Circular command FIFO for one lane, reporting empty and almost-full to the arbiter and top
`timescale 1ns/1ps

module read_command_queue #(
	parameter int QUEUE_DEPTH         = 16,
	parameter int QUEUE_ALFULL_MARGIN = 4
) (
	input  logic                        clock,
	input  logic                        rstn_internal,
	input  logic                        push,
	input  read_bus_pkg::read_command_t push_command,
	input  logic                        pop,
	output read_bus_pkg::read_command_t head,
	output logic                        empty,
	output logic                        alfull
);

	localparam int PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

	read_bus_pkg::read_command_t entries [QUEUE_DEPTH];
	logic [PTR_BITS-1:0]         write_ptr;
	logic [PTR_BITS-1:0]         read_ptr;
	logic [COUNT_BITS-1:0]       count;
	logic                        full;

	// Wraps at the last entry so any depth works
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	////////////////////
	// Pointers and occupancy
	////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
		end else begin
			if (push) begin
				write_ptr <= next_ptr(write_ptr);
			end
			if (pop) begin
				read_ptr <= next_ptr(read_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			entries[write_ptr] <= push_command;
		end
	end

	assign head   = entries[read_ptr];
	assign empty  = (count == '0);
	assign full   = (count == COUNT_BITS'(QUEUE_DEPTH));
	// Raised once free entries drop to the margin
	assign alfull = (COUNT_BITS'(QUEUE_DEPTH) - count) <= COUNT_BITS'(QUEUE_ALFULL_MARGIN);

	// Upstream honours command_stall, so the queue never overflows
	assert property (@(posedge clock) disable iff (!rstn_internal) push |-> !full);
	assert property (@(posedge clock) disable iff (!rstn_internal) pop |-> !empty);

endmodule

// ==== hw/read_data_router.sv ====
// Result stage routing returning lines by array kind and delaying read responses by two cycles
`timescale 1ns/1ps

module read_data_router (
	input  logic                         clock,
	input  logic                         rstn_internal,
	input  logic                         enabled,
	input  read_bus_pkg::read_data_t     read_data_in,
	input  read_bus_pkg::read_response_t read_response_in,
	output read_bus_pkg::read_data_t     read_job_out,
	output graph_array_pkg::edge_data_t  edge_data_out,
	output read_bus_pkg::read_response_t read_response_out
);

	logic                            data_valid_q;
	read_bus_pkg::read_data_t        data_q;
	logic                            response_valid_q;
	read_bus_pkg::read_response_t    response_q;
	graph_array_pkg::edge_element_t  [graph_array_pkg::ELEMENTS_PER_LINE-1:0] line_elements;
	logic                            job_valid;
	read_bus_pkg::read_data_t        job_line;
	logic                            edge_valid;
	graph_array_pkg::edge_element_t  edge_element;
	read_bus_pkg::read_tag_t         edge_tag;
	logic                            response_valid;
	read_bus_pkg::read_response_t    response_line;

	////////////////////
	// Input register
	////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			data_valid_q     <= 1'b0;
			response_valid_q <= 1'b0;
		end else begin
			data_valid_q     <= enabled && read_data_in.valid;
			response_valid_q <= enabled && read_response_in.valid;
		end
	end

	always_ff @(posedge clock) begin
		data_q     <= read_data_in;
		response_q <= read_response_in;
	end

	// Element 0 sits in the low 32 bits
	assign line_elements = data_q.line;

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			job_valid      <= 1'b0;
			edge_valid     <= 1'b0;
			response_valid <= 1'b0;
		end else begin
			job_valid      <= enabled && data_valid_q &&
				(data_q.kind == graph_array_pkg::array_job);
			edge_valid     <= enabled && data_valid_q &&
				(data_q.kind == graph_array_pkg::array_edge_data);
			response_valid <= enabled && response_valid_q;
		end
	end

	always_ff @(posedge clock) begin
		job_line      <= data_q;
		edge_element  <= line_elements[data_q.element];
		edge_tag      <= data_q.tag;
		response_line <= response_q;
	end

	always_comb begin
		read_job_out       = job_line;
		read_job_out.valid = job_valid;
	end

	assign edge_data_out.valid   = edge_valid;
	assign edge_data_out.element = edge_element;
	assign edge_data_out.tag     = edge_tag;

	always_comb begin
		read_response_out       = response_line;
		read_response_out.valid = response_valid;
	end

endmodule

// ==== hw/vertex_cache_reuse_control.sv ====
// Top of the read-side traffic controller, holding the enable register and wiring all stages
`timescale 1ns/1ps

module vertex_cache_reuse_control #(
	parameter int QUEUE_DEPTH         = 16,
	parameter int QUEUE_ALFULL_MARGIN = 4
) (
	input  logic                         clock,
	input  logic                         rstn_internal,
	input  logic                         enabled_in,
	input  logic                         read_buffer_alfull,
	input  read_bus_pkg::read_command_t  command_in,
	input  read_bus_pkg::read_data_t     read_data_in,
	input  read_bus_pkg::read_response_t read_response_in,
	output logic                         command_stall,
	output read_bus_pkg::read_command_t  read_command_out,
	output read_bus_pkg::read_data_t     read_job_out,
	output graph_array_pkg::edge_data_t  edge_data_out,
	output read_bus_pkg::read_response_t read_response_out
);

	logic                        enabled;
	read_bus_pkg::read_command_t lane_command;
	graph_array_pkg::lane_t      lane_select;
	logic                        job_push;
	logic                        edge_push;
	logic                        job_pop;
	logic                        edge_pop;
	read_bus_pkg::read_command_t job_head;
	read_bus_pkg::read_command_t edge_head;
	logic                        job_empty;
	logic                        edge_empty;
	logic                        job_alfull;
	logic                        edge_alfull;

	// Enable takes effect one cycle after enabled_in
	always_ff @(posedge clock or negedge rstn_internal) begin
		if (!rstn_internal) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	assign command_stall = job_alfull | edge_alfull;

	////////////////////
	// Command path
	////////////////////

	read_command_classifier classifier (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.enabled       (enabled),
		.command_in    (command_in),
		.lane_command  (lane_command),
		.lane_select   (lane_select)
	);

	assign job_push  = lane_command.valid && (lane_select == graph_array_pkg::lane_job);
	assign edge_push = lane_command.valid && (lane_select == graph_array_pkg::lane_edge);

	read_command_queue #(
		.QUEUE_DEPTH         (QUEUE_DEPTH),
		.QUEUE_ALFULL_MARGIN (QUEUE_ALFULL_MARGIN)
	) job_queue (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.push          (job_push),
		.push_command  (lane_command),
		.pop           (job_pop),
		.head          (job_head),
		.empty         (job_empty),
		.alfull        (job_alfull)
	);

	read_command_queue #(
		.QUEUE_DEPTH         (QUEUE_DEPTH),
		.QUEUE_ALFULL_MARGIN (QUEUE_ALFULL_MARGIN)
	) edge_queue (
		.clock         (clock),
		.rstn_internal (rstn_internal),
		.push          (edge_push),
		.push_command  (lane_command),
		.pop           (edge_pop),
		.head          (edge_head),
		.empty         (edge_empty),
		.alfull        (edge_alfull)
	);

	read_command_arbiter arbiter (
		.clock              (clock),
		.rstn_internal      (rstn_internal),
		.enabled            (enabled),
		.read_buffer_alfull (read_buffer_alfull),
		.job_head           (job_head),
		.edge_head          (edge_head),
		.job_empty          (job_empty),
		.edge_empty         (edge_empty),
		.job_pop            (job_pop),
		.edge_pop           (edge_pop),
		.read_command_out   (read_command_out)
	);

	////////////////////
	// Data and response path
	////////////////////

	read_data_router router (
		.clock             (clock),
		.rstn_internal     (rstn_internal),
		.enabled           (enabled),
		.read_data_in      (read_data_in),
		.read_response_in  (read_response_in),
		.read_job_out      (read_job_out),
		.edge_data_out     (edge_data_out),
		.read_response_out (read_response_out)
	);

endmodule

// ==== sources.f ====
hw/graph_array_pkg.sv
hw/read_bus_pkg.sv
hw/read_command_classifier.sv
hw/read_command_queue.sv
hw/read_command_arbiter.sv
hw/read_data_router.sv
hw/vertex_cache_reuse_control.sv
tb/tb_vertex_cache_reuse_control.sv

// ==== tb/tb_vertex_cache_reuse_control.sv ====
// Testbench driving random commands, lines and responses into the controller and checking a model
`timescale 1ns/1ps

module tb_vertex_cache_reuse_control;

	logic                         clock;
	logic                         rstn_internal;
	logic                         enabled_in;
	logic                         read_buffer_alfull;
	read_bus_pkg::read_command_t  command_in;
	read_bus_pkg::read_data_t     read_data_in;
	read_bus_pkg::read_response_t read_response_in;
	logic                         command_stall;
	read_bus_pkg::read_command_t  read_command_out;
	read_bus_pkg::read_data_t     read_job_out;
	graph_array_pkg::edge_data_t  edge_data_out;
	read_bus_pkg::read_response_t read_response_out;

	// Pending commands per lane, in grant order
	read_bus_pkg::read_command_t  job_expected [$];
	read_bus_pkg::read_command_t  edge_expected [$];
	// Input history sampled on falling edges
	// Index 0 holds the most recent sample
	read_bus_pkg::read_data_t     data_hist [2];
	read_bus_pkg::read_response_t response_hist [2];
	logic [2:0]                   enable_hist;
	logic [1:0]                   alfull_hist;
	logic                         check_alternation;
	logic                         have_last_lane;
	graph_array_pkg::lane_t       last_lane;
	int                           error_count;
	int                           timeout_count;
	int                           command_count;

	vertex_cache_reuse_control #(
		.QUEUE_DEPTH         (16),
		.QUEUE_ALFULL_MARGIN (4)
	) DUT (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic read_bus_pkg::read_command_t make_command(
		input graph_array_pkg::array_kind_t kind);
		read_bus_pkg::read_command_t c;
		c.valid   = 1'b1;
		c.address = $urandom;
		c.kind    = kind;
		c.element = graph_array_pkg::element_index_t'($urandom_range(7, 0));
		c.tag     = read_bus_pkg::read_tag_t'($urandom);
		return c;
	endfunction

	function automatic read_bus_pkg::read_data_t make_data();
		read_bus_pkg::read_data_t d;
		d.valid   = ($urandom_range(3, 0) != 0);
		d.kind    = graph_array_pkg::array_kind_t'($urandom_range(3, 0));
		d.element = graph_array_pkg::element_index_t'($urandom_range(7, 0));
		d.tag     = read_bus_pkg::read_tag_t'($urandom);
		for (int i = 0; i < graph_array_pkg::ELEMENTS_PER_LINE; i++) begin
			d.line[32*i +: 32] = $urandom;
		end
		return d;
	endfunction

	function automatic read_bus_pkg::read_response_t make_response();
		read_bus_pkg::read_response_t r;
		r.valid  = ($urandom_range(1, 0) != 0);
		r.tag    = read_bus_pkg::read_tag_t'($urandom);
		r.status = 2'($urandom_range(3, 0));
		return r;
	endfunction

	// Element 0 is the least significant 32 bits of the line
	function automatic graph_array_pkg::edge_element_t edge_slice(input read_bus_pkg::read_data_t d);
		return graph_array_pkg::edge_element_t'(d.line >> (32 * int'(d.element)));
	endfunction

	task automatic drive_idle();
		command_in       <= '0;
		read_data_in     <= '0;
		read_response_in <= '0;
	endtask

	task automatic drive_random_cycle(input int command_percent);
		@(posedge clock);
		if (!command_stall && $urandom_range(99, 0) < command_percent) begin
			command_in <= make_command(graph_array_pkg::array_kind_t'($urandom_range(3, 0)));
		end else begin
			command_in <= '0;
		end
		read_data_in     <= make_data();
		read_response_in <= make_response();
	endtask

	task automatic send_command(input graph_array_pkg::array_kind_t kind);
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (command_stall && cycles < 100) begin
			command_in <= '0;
			@(posedge clock);
			cycles++;
		end
		assert (!command_stall) else begin
			$display("Error: command_stall stayed high for %0d cycles", cycles);
			timeout_count++;
		end
		command_in <= make_command(kind);
	endtask

	task automatic wait_for_drain(input int limit);
		int cycles;
		cycles = 0;
		drive_idle();
		repeat (3) @(posedge clock);
		while ((job_expected.size() != 0 || edge_expected.size() != 0) && cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		assert (job_expected.size() == 0 && edge_expected.size() == 0) else begin
			$display("Error: pending commands did not drain within %0d cycles", limit);
			timeout_count++;
		end
	endtask

	////////////////////
	// Output checks
	////////////////////

	task automatic check_command_output(input logic grant_allowed);
		read_bus_pkg::read_command_t expected;
		graph_array_pkg::lane_t      lane;
		logic                        kind_ok;
		logic                        other_pending;
		int                          pending;
		if (!read_command_out.valid) begin
			return;
		end
		assert (grant_allowed) else begin
			$display("Error: command granted while disabled or under back-pressure");
			error_count++;
		end
		kind_ok = (read_command_out.kind == graph_array_pkg::array_job) ||
			(read_command_out.kind == graph_array_pkg::array_edge_data);
		assert (kind_ok) else begin
			$display("Error: command of a vertex or property kind reached the read port");
			error_count++;
		end
		if (!kind_ok) begin
			return;
		end
		if (read_command_out.kind == graph_array_pkg::array_job) begin
			lane          = graph_array_pkg::lane_job;
			pending       = job_expected.size();
			other_pending = (edge_expected.size() != 0);
		end else begin
			lane          = graph_array_pkg::lane_edge;
			pending       = edge_expected.size();
			other_pending = (job_expected.size() != 0);
		end
		// Both lanes loaded, so the same lane twice means round robin broke
		assert (!(check_alternation && have_last_lane && lane == last_lane &&
			other_pending)) else begin
			$display("Error: same lane granted twice while the other lane waited");
			error_count++;
		end
		have_last_lane = 1'b1;
		last_lane      = lane;
		assert (pending != 0) else begin
			$display("Error: command appeared on the read port with none pending in its lane");
			error_count++;
		end
		if (pending == 0) begin
			return;
		end
		if (lane == graph_array_pkg::lane_job) begin
			expected = job_expected.pop_front();
		end else begin
			expected = edge_expected.pop_front();
		end
		assert (read_command_out == expected) else begin
			$display("** Error: read_command_out = %h, expected %h", read_command_out, expected);
			error_count++;
		end
		command_count++;
	endtask

	task automatic check_router_outputs(input logic pipe_enabled);
		read_bus_pkg::read_data_t     d;
		read_bus_pkg::read_response_t r;
		graph_array_pkg::edge_data_t  edge_out;
		logic                         job_valid;
		logic                         edge_valid;
		logic                         response_valid;
		d              = data_hist[1];
		r              = response_hist[1];
		job_valid      = pipe_enabled && d.valid && (d.kind == graph_array_pkg::array_job);
		edge_valid     = pipe_enabled && d.valid && (d.kind == graph_array_pkg::array_edge_data);
		response_valid = pipe_enabled && r.valid;
		edge_out.valid   = 1'b1;
		edge_out.element = edge_slice(d);
		edge_out.tag     = d.tag;
		assert (read_job_out.valid == job_valid && (!job_valid || read_job_out == d)) else begin
			$display("** Error: read_job_out = %h, expected valid %h line %h",
				read_job_out, job_valid, d);
			error_count++;
		end
		assert (edge_data_out.valid == edge_valid && (!edge_valid || edge_data_out == edge_out))
		else begin
			$display("** Error: edge_data_out = %h, expected valid %h data %h",
				edge_data_out, edge_valid, edge_out);
			error_count++;
		end
		assert (read_response_out.valid == response_valid &&
			(!response_valid || read_response_out == r)) else begin
			$display("** Error: read_response_out = %h, expected valid %h response %h",
				read_response_out, response_valid, r);
			error_count++;
		end
	endtask

	// Model update and output checks on each falling edge
	always @(negedge clock) begin
		if (rstn_internal) begin
			if (command_in.valid && enable_hist[0]) begin
				if (command_in.kind == graph_array_pkg::array_job) begin
					job_expected.push_back(command_in);
				end else if (command_in.kind == graph_array_pkg::array_edge_data) begin
					edge_expected.push_back(command_in);
				end
			end
			check_command_output(enable_hist[1] && !alfull_hist[1]);
			check_router_outputs(enable_hist[2] && enable_hist[1]);
		end
		data_hist[1]     = data_hist[0];
		data_hist[0]     = read_data_in;
		response_hist[1] = response_hist[0];
		response_hist[0] = read_response_in;
		enable_hist      = {enable_hist[1:0], enabled_in};
		alfull_hist      = {alfull_hist[0], read_buffer_alfull};
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int jobs_left;
		int edges_left;
		void'($urandom(32'hc4f2ee5b));
		error_count        = 0;
		timeout_count      = 0;
		command_count      = 0;
		check_alternation  = 1'b0;
		have_last_lane     = 1'b0;
		last_lane          = graph_array_pkg::lane_job;
		data_hist[0]       = '0;
		data_hist[1]       = '0;
		response_hist[0]   = '0;
		response_hist[1]   = '0;
		enable_hist        = '0;
		alfull_hist        = '0;
		rstn_internal      = 1'b0;
		enabled_in         = 1'b0;
		read_buffer_alfull = 1'b0;
		command_in         = '0;
		read_data_in       = '0;
		read_response_in   = '0;
		repeat (8) @(posedge clock);
		rstn_internal <= 1'b1;
		@(posedge clock);
		assert (!command_stall) else begin
			$display("** Error: command_stall = %h, expected 0", command_stall);
			error_count++;
		end
		enabled_in <= 1'b1;

		// Mixed traffic with occasional back-pressure and disable
		for (int i = 0; i < 600; i++) begin
			drive_random_cycle(60);
			if ((i % 25) == 0) begin
				read_buffer_alfull <= ($urandom_range(3, 0) == 0);
			end
			if ((i % 40) == 0) begin
				enabled_in <= ($urandom_range(4, 0) != 0);
			end
		end
		read_buffer_alfull <= 1'b0;
		enabled_in         <= 1'b1;
		wait_for_drain(300);

		// Load both lanes under back-pressure, then release
		read_buffer_alfull <= 1'b1;
		jobs_left  = 6;
		edges_left = 6;
		while (jobs_left + edges_left > 0) begin
			if (edges_left == 0 || (jobs_left != 0 && $urandom_range(1, 0) == 0)) begin
				send_command(graph_array_pkg::array_job);
				jobs_left--;
			end else begin
				send_command(graph_array_pkg::array_edge_data);
				edges_left--;
			end
		end
		@(posedge clock);
		drive_idle();
		repeat (3) @(posedge clock);
		check_alternation = 1'b1;
		have_last_lane    = 1'b0;
		read_buffer_alfull <= 1'b0;
		wait_for_drain(100);
		check_alternation = 1'b0;

		// Queue a few commands, then disable while lines keep arriving
		read_buffer_alfull <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			send_command(($urandom_range(1, 0) == 0) ? graph_array_pkg::array_job :
				graph_array_pkg::array_edge_data);
		end
		@(posedge clock);
		drive_idle();
		enabled_in <= 1'b0;
		repeat (2) @(posedge clock);
		read_buffer_alfull <= 1'b0;
		for (int i = 0; i < 12; i++) begin
			drive_random_cycle(0);
		end
		drive_idle();
		assert (job_expected.size() + edge_expected.size() == 4) else begin
			$display("Error: queued commands left while disabled");
			error_count++;
		end
		enabled_in <= 1'b1;
		wait_for_drain(100);

		repeat (4) @(posedge clock);
		$display("Commands checked %0d, errors %0d, timeouts %0d",
			command_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
